/* hdl/mips_defs.svh */
// widths, reset pc, register count, opcode and funct encodings
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define DATA_W      32              // data and instruction word
`define REG_NUM     32              // general registers incl. r0
`define REG_ADDR_W  5               // register number
`define SHAMT_W     5               // shift amount field
`define RESET_PC    32'hBFC0_0000   // pc of first instr after reset
`define WEN_W       4               // trace byte enables

`define OP_SPECIAL  6'h00   // register forms, funct selects op
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0A
`define OP_SLTIU    6'h0B
`define OP_ANDI     6'h0C
`define OP_ORI      6'h0D
`define OP_XORI     6'h0E
`define OP_LUI      6'h0F

`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2A
`define FN_SLTU     6'h2B

`endif

/* hdl/mips_pkg.sv */
// shared types: data word, register number, shift amount, alu op enum, stage structs
`include "mips_defs.svh"

package mips_pkg;

    typedef logic [`DATA_W-1:0]     word_t;     // data or instruction word
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t; // gpr number
    typedef logic [`SHAMT_W-1:0]    shamt_t;    // shift distance

    typedef enum logic [3:0] {
        ALU_ADD,    // wrap-around add
        ALU_SUB,    // wrap-around subtract
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,    // signed compare
        ALU_SLTU,   // unsigned compare
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI     // imm to upper half
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        logic      valid;   // cleared for bubbles
        word_t     pc;
        alu_op_e   alu_op;
        word_t     opa;     // rs after bypass
        word_t     opb;     // rt after bypass or extended imm
        shamt_t    shamt;
        reg_addr_t dst;
        logic      wr;      // valid write to nonzero gpr
    } dec_exe_t;

    // execute to write-back, also the bypass payload
    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;
        reg_addr_t dst;
        logic      wr;
    } exe_res_t;

endpackage

/* hdl/reg_file.sv */
// general register file, 31 writable entries, r0 hardwired to zero
`timescale 1ns/1ps
`include "mips_defs.svh"

module reg_file import mips_pkg::*; (
    input  logic      aclk,
    input  logic      arst_n,
    input  reg_addr_t raddr_a,  // rs port
    input  reg_addr_t raddr_b,  // rt port
    output word_t     rdata_a,
    output word_t     rdata_b,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t [`REG_NUM-1:1] regs;   // no storage behind r0

    always_ff @(posedge aclk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;   // visible to reads after this edge
        end
    end

    // async read with r0 forced to zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // decode drops r0 writes before they reach this port
    a_r0_write_dropped : assert property (
        @(posedge aclk) disable iff (!arst_n)
        we |-> (waddr != '0)
    );

endmodule

/* hdl/inst_decode.sv */
// decode stage: instruction register, pc counter, field decode, bypassed register read
`timescale 1ns/1ps
`include "mips_defs.svh"

module inst_decode import mips_pkg::*; (
    input  logic     aclk,
    input  logic     arst_n,
    input  logic     instr_valid,
    input  word_t    instr,
    input  exe_res_t exe_fwd,   // result now in execute
    input  exe_res_t wb_fwd,    // result headed into the rf
    output dec_exe_t dec_out
);

    logic      ir_valid;
    word_t     ir_instr;
    word_t     ir_pc;
    word_t     pc_cnt;      // pc for the next valid instr
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t dst;
    logic      use_imm;     // i-type, rt is the destination
    logic      imm_zext;
    word_t     imm_ext;
    alu_op_e   alu_op;
    logic      legal;
    word_t     rf_a;
    word_t     rf_b;

    // newest producer wins, r0 never bypassed
    function automatic word_t bypass(input reg_addr_t addr, input word_t rf_data,
                                     input exe_res_t e, input exe_res_t w);
        word_t data;
        data = rf_data;
        if ((addr != '0) && e.wr && (e.dst == addr)) begin
            data = e.result;
        end else if ((addr != '0) && w.wr && (w.dst == addr)) begin
            data = w.result;
        end
        return data;
    endfunction

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ir_valid <= 1'b0;
            pc_cnt   <= `RESET_PC;
        end else begin
            ir_valid <= instr_valid;
            if (instr_valid) begin
                pc_cnt <= pc_cnt + 32'd4;   // bubbles hold the pc
            end
        end
    end

    always_ff @(posedge aclk) begin
        ir_instr <= instr;
        ir_pc    <= pc_cnt;
    end

    assign opcode   = ir_instr[31:26];
    assign rs       = ir_instr[25:21];
    assign rt       = ir_instr[20:16];
    assign rd       = ir_instr[15:11];
    assign funct    = ir_instr[5:0];
    assign use_imm  = (opcode != `OP_SPECIAL);
    assign dst      = use_imm ? rt : rd;
    assign imm_zext = (opcode == `OP_ANDI) || (opcode == `OP_ORI) ||
                      (opcode == `OP_XORI) || (opcode == `OP_LUI);
    assign imm_ext  = imm_zext ? {16'h0000, ir_instr[15:0]}
                               : {{16{ir_instr[15]}}, ir_instr[15:0]};

    always_comb begin
        alu_op = ALU_ADD;
        legal  = 1'b1;
        case (opcode)
            `OP_SPECIAL: begin
                case (funct)
                    `FN_ADDU: alu_op = ALU_ADD;
                    `FN_SUBU: alu_op = ALU_SUB;
                    `FN_AND:  alu_op = ALU_AND;
                    `FN_OR:   alu_op = ALU_OR;
                    `FN_XOR:  alu_op = ALU_XOR;
                    `FN_NOR:  alu_op = ALU_NOR;
                    `FN_SLT:  alu_op = ALU_SLT;
                    `FN_SLTU: alu_op = ALU_SLTU;
                    `FN_SLL:  alu_op = ALU_SLL;
                    `FN_SRL:  alu_op = ALU_SRL;
                    `FN_SRA:  alu_op = ALU_SRA;
                    default:  legal  = 1'b0;
                endcase
            end
            `OP_ADDIU: alu_op = ALU_ADD;
            `OP_SLTI:  alu_op = ALU_SLT;
            `OP_SLTIU: alu_op = ALU_SLTU;   // sign-extended, compared unsigned
            `OP_ANDI:  alu_op = ALU_AND;
            `OP_ORI:   alu_op = ALU_OR;
            `OP_XORI:  alu_op = ALU_XOR;
            `OP_LUI:   alu_op = ALU_LUI;
            default:   legal  = 1'b0;
        endcase
    end

    reg_file reg_file_i (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .raddr_a (rs),
        .raddr_b (rt),
        .rdata_a (rf_a),
        .rdata_b (rf_b),
        .we      (wb_fwd.wr),
        .waddr   (wb_fwd.dst),
        .wdata   (wb_fwd.result)
    );

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            dec_out <= '0;
        end else begin
            dec_out.valid  <= ir_valid;
            dec_out.pc     <= ir_pc;
            dec_out.alu_op <= alu_op;
            dec_out.opa    <= bypass(rs, rf_a, exe_fwd, wb_fwd);
            dec_out.opb    <= use_imm ? imm_ext : bypass(rt, rf_b, exe_fwd, wb_fwd);
            dec_out.shamt  <= ir_instr[10:6];
            dec_out.dst    <= dst;
            dec_out.wr     <= ir_valid && legal && (dst != '0);   // r0 writes dropped here
        end
    end

    a_legal_instr : assert property (
        @(posedge aclk) disable iff (!arst_n) ir_valid |-> legal
    );

endmodule

/* hdl/alu_execute.sv */
// execute stage: adder, logic ops, compares, shifter, execute/result register
`timescale 1ns/1ps

module alu_execute import mips_pkg::*; (
    input  logic     aclk,
    input  logic     arst_n,
    input  dec_exe_t dec_in,
    output exe_res_t exe_fwd,   // same-cycle result for bypass
    output exe_res_t exe_out
);

    word_t sum;
    word_t diff;
    logic  lt_s;
    logic  lt_u;
    word_t alu_res;

    assign sum  = dec_in.opa + dec_in.opb;  // wraps, no overflow trap
    assign diff = dec_in.opa - dec_in.opb;
    assign lt_s = $signed(dec_in.opa) < $signed(dec_in.opb);
    assign lt_u = dec_in.opa < dec_in.opb;

    always_comb begin
        case (dec_in.alu_op)
            ALU_ADD:  alu_res = sum;
            ALU_SUB:  alu_res = diff;
            ALU_AND:  alu_res = dec_in.opa & dec_in.opb;
            ALU_OR:   alu_res = dec_in.opa | dec_in.opb;
            ALU_XOR:  alu_res = dec_in.opa ^ dec_in.opb;
            ALU_NOR:  alu_res = ~(dec_in.opa | dec_in.opb);
            ALU_SLT:  alu_res = word_t'(lt_s);
            ALU_SLTU: alu_res = word_t'(lt_u);
            ALU_SLL:  alu_res = dec_in.opb << dec_in.shamt;     // shifts act on rt
            ALU_SRL:  alu_res = dec_in.opb >> dec_in.shamt;
            ALU_SRA:  alu_res = word_t'($signed(dec_in.opb) >>> dec_in.shamt);
            ALU_LUI:  alu_res = {dec_in.opb[15:0], 16'h0000};
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        exe_fwd.valid  = dec_in.valid;
        exe_fwd.pc     = dec_in.pc;
        exe_fwd.result = alu_res;
        exe_fwd.dst    = dec_in.dst;
        exe_fwd.wr     = dec_in.wr;     // already gated by valid in decode
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            exe_out <= '0;
        end else begin
            exe_out <= exe_fwd;
        end
    end

endmodule

/* hdl/write_back.sv */
// write-back stage: rf write port, last pipeline register, golden-trace outputs
`timescale 1ns/1ps
`include "mips_defs.svh"

module write_back import mips_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n,
    input  exe_res_t          exe_in,
    output exe_res_t          wb_fwd,           // rf write, also bypass source
    output word_t             debug_wb_pc,
    output word_t             debug_wb_rf_wdata,
    output logic [`WEN_W-1:0] debug_wb_rf_wen,
    output reg_addr_t         debug_wb_rf_wnum
);

    exe_res_t wb_q;     // retiring instruction

    // rf write lands on the same edge that loads wb_q
    assign wb_fwd = exe_in;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wb_q <= '0;
        end else begin
            wb_q <= exe_in;
        end
    end

    assign debug_wb_pc       = wb_q.pc;
    assign debug_wb_rf_wdata = wb_q.result;
    assign debug_wb_rf_wen   = wb_q.wr ? {`WEN_W{1'b1}} : {`WEN_W{1'b0}};  // full word or none
    assign debug_wb_rf_wnum  = wb_q.dst;

    // decode must have dropped every r0 write
    a_no_r0_trace : assert property (
        @(posedge aclk) disable iff (!arst_n)
        (debug_wb_rf_wen != '0) |-> (debug_wb_rf_wnum != '0)
    );

endmodule

/* hdl/mips_core_top.sv */
// core top: decode, execute and write-back stages with bypass wiring
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core_top import mips_pkg::*; (
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              instr_valid,  // one instr per cycle while high
    input  word_t             instr,
    output word_t             debug_wb_pc,
    output word_t             debug_wb_rf_wdata,
    output logic [`WEN_W-1:0] debug_wb_rf_wen,
    output reg_addr_t         debug_wb_rf_wnum
);

    dec_exe_t dec_exe;      // decode/execute register
    exe_res_t exe_fwd;      // execute result, combinational
    exe_res_t exe_res;      // execute/result register
    exe_res_t wb_fwd;       // rf write port

    inst_decode inst_decode_i (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .exe_fwd     (exe_fwd),
        .wb_fwd      (wb_fwd),
        .dec_out     (dec_exe)
    );

    alu_execute alu_execute_i (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .dec_in  (dec_exe),
        .exe_fwd (exe_fwd),
        .exe_out (exe_res)
    );

    write_back write_back_i (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .exe_in            (exe_res),
        .wb_fwd            (wb_fwd),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

endmodule

/* testbench/tb_mips_core.sv */
// testbench for mips_core_top: clock, reset, stim-file instructions, trace checks, timeout
`timescale 1ns/1ps
`include "mips_defs.svh"

module tb_mips_core import mips_pkg::*; ();

    typedef struct packed {
        logic        valid;     // low for a bubble line
        word_t       instr;
        reg_addr_t   wnum;
        word_t       wdata;
        logic [15:0] line_no;   // line in the stim file
    } stim_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;        // from the pc rule, not from the file
        reg_addr_t   wnum;
        word_t       wdata;
        logic [15:0] line_no;   // 0 for reset and flush slots
    } trace_t;

    logic              aclk;
    logic              arst_n;
    logic              instr_valid;
    word_t             instr;
    word_t             debug_wb_pc;
    word_t             debug_wb_rf_wdata;
    logic [`WEN_W-1:0] debug_wb_rf_wen;
    reg_addr_t         debug_wb_rf_wnum;

    stim_t  stim_q[$];
    trace_t exp_q[$];       // in flight, oldest first
    int     cycles;
    int     cycle_limit;
    int     errors;         // single mismatches and other failures
    int     tests_passed;
    int     tests_failed;

    mips_core_top mips_core_top_i (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .instr_valid       (instr_valid),
        .instr             (instr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;   // 20 ns period
    end

    // cycle counter, the limit is set once the stim file is read
    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

    task automatic read_stim();
        int          fd;
        int          line_no;
        string       text;
        stim_t       s;
        logic [31:0] v;
        logic [31:0] ins;
        logic [31:0] wn;
        logic [31:0] wd;
        line_no = 0;
        fd = $fopen("testbench/mips_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/mips_stim.txt for reading");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                line_no++;
                if ((text.len() > 0) && (text.getc(0) != "#")) begin  // skip column notes
                    if ($sscanf(text, "%h %h %h %h", v, ins, wn, wd) == 4) begin
                        s.valid   = v[0];
                        s.instr   = ins;
                        s.wnum    = wn[4:0];
                        s.wdata   = wd;
                        s.line_no = line_no[15:0];
                        stim_q.push_back(s);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // compare the trace now on the debug outputs with one expected slot
    task automatic check_trace(input trace_t e);
        int                bad;
        logic [`WEN_W-1:0] exp_wen;
        bad     = 0;
        exp_wen = (e.valid && (e.wnum != '0)) ? {`WEN_W{1'b1}} : '0;   // r0 writes invisible
        if (debug_wb_rf_wen !== exp_wen) begin
            $display("[FAIL] %0t debug_wb_rf_wen expected %h got %h",
                     $time, exp_wen, debug_wb_rf_wen);
            bad++;
        end
        if (e.valid && (debug_wb_pc !== e.pc)) begin
            $display("[FAIL] %0t debug_wb_pc expected %h got %h", $time, e.pc, debug_wb_pc);
            bad++;
        end
        if (e.valid && (debug_wb_rf_wnum !== e.wnum)) begin
            $display("[FAIL] %0t debug_wb_rf_wnum expected %0d got %0d",
                     $time, e.wnum, debug_wb_rf_wnum);
            bad++;
        end
        if ((exp_wen != '0) && (debug_wb_rf_wdata !== e.wdata)) begin
            $display("[FAIL] %0t debug_wb_rf_wdata expected %h got %h",
                     $time, e.wdata, debug_wb_rf_wdata);
            bad++;
        end
        errors += bad;
        if (e.line_no != 0) begin
            if (bad == 0) begin
                tests_passed++;
                $display("line %0d valid %0b pc %h: ok", e.line_no, e.valid, e.pc);
            end else begin
                tests_failed++;
                $display("line %0d valid %0b pc %h: %0d mismatches", e.line_no, e.valid, e.pc, bad);
            end
        end
    endtask

    initial begin
        trace_t e;
        stim_t  s;
        word_t  exp_pc;
        int     n_stim;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_limit  = 40;
        exp_pc       = `RESET_PC;
        read_stim();
        n_stim      = stim_q.size();
        cycle_limit = n_stim + 40;  // reset, pipeline fill and flush fit inside
        if (n_stim == 0) begin
            $display("stim file holds no instruction lines");
            errors++;
        end
        repeat (15) @(posedge aclk);
        @(negedge aclk);
        e = '0;
        check_trace(e);     // reset state, wen zero
        if (debug_wb_pc !== '0) begin
            $display("[FAIL] %0t debug_wb_pc expected %h got %h", $time, 32'h0, debug_wb_pc);
            errors++;
        end
        @(posedge aclk);    // 16th cycle in reset
        #2 arst_n = 1'b1;
        repeat (4) exp_q.push_back('0);     // pipeline still empty after reset
        for (int c = 0; c < n_stim + 4; c++) begin
            s = '0;
            if (c < n_stim) begin
                s = stim_q[c];
            end
            instr_valid = s.valid;
            instr       = s.instr;
            e.valid     = s.valid;
            e.pc        = exp_pc;
            e.wnum      = s.wnum;
            e.wdata     = s.wdata;
            e.line_no   = s.line_no;
            if (s.valid) begin
                exp_pc = exp_pc + 32'd4;    // bubbles hold the pc
            end
            exp_q.push_back(e);
            @(negedge aclk);                // mid-cycle, trace is stable
            check_trace(exp_q.pop_front());
            @(posedge aclk);
            #2;
        end
        $display("tests: %0d passed, %0d failed, %0d mismatches or errors",
                 tests_passed, tests_failed, errors);
        if ((errors == 0) && (tests_failed == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* testbench/mips_stim.txt */
# valid(hex) instr(hex) expected_wnum(hex) expected_wdata(hex)
# wdata is ignored when nothing is written (bubble or r0); pc comes from the testbench
1 3C018000 01 80000000
1 342100F0 01 800000F0
1 2402FFFF 02 FFFFFFFF
1 00221821 03 800000EF
0 00000000 00 00000000
1 00612023 04 FFFFFFFF
1 0080282A 05 00000001
1 0080302B 06 00000000
1 28478000 07 00000000
1 2C28FFFF 08 00000001
1 30498F0F 09 00008F0F
1 340AA5A5 0A 0000A5A5
1 394BFFFF 0B 00005A5A
1 00016100 0C 00000F00
1 00016902 0D 0800000F
1 00017103 0E F800000F
1 01AE7824 0F 0800000F
1 018F8025 10 08000F0F
1 020A8826 11 0800AAAA
1 02209027 12 F7FF5555
0 00000000 00 00000000
0 00000000 00 00000000
1 24200005 00 800000F5
1 00009821 13 00000000
1 24147FFF 14 00007FFF
1 3C141234 14 12340000
1 0294A821 15 24680000
1 0015B023 16 DB980000
1 0016BFC3 17 FFFFFFFF
1 0016C7C2 18 00000001
1 26F90002 19 00000001
0 00000000 00 00000000
1 0019D02B 1A 00000001

/* all.f */
+incdir+hdl
hdl/mips_pkg.sv
hdl/reg_file.sv
hdl/inst_decode.sv
hdl/alu_execute.sv
hdl/write_back.sv
hdl/mips_core_top.sv
testbench/tb_mips_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mips_core
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
